/* all.f */
+incdir+verilog
verilog/video_pkg.sv
verilog/game_pkg.sv
verilog/screen_mode_ctrl.sv
verilog/spaceship_ctrl.sv
verilog/alien_formation.sv
verilog/pixel_compositor.sv
verilog/invaders_display.sv
tests/invaders_checker.sv
tests/tb_invaders.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the invaders testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f all.f --top-module tb_invaders -o tb_invaders
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_invaders)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1

/* tests/tb_invaders.sv */
`timescale 1ns/1ps
`default_nettype none

`include "invaders_defines.svh"

module tb_invaders
	import video_pkg::*;
	import game_pkg::*;
();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 8;
	localparam int N_RANDOM     = 200;
	localparam int SHIP_LEFT    = 90;
	localparam int SHIP_RIGHT   = 160;
	localparam int FORM_TICKS   = 2000;
	localparam int N_SWEEP      = 1500;
	localparam int LAST_OFS     = (`ALIEN_COUNT - 1) * `ALIEN_PITCH;
	// Rough cycle budget with eight button presses of eight cycles
	localparam int TEST_CYCLES  = RESET_CYCLES + 2 * N_RANDOM + 8 * 8 + 200 +
		(SHIP_LEFT + SHIP_RIGHT) * 8 + FORM_TICKS * 10 + N_SWEEP * 3;

	logic          clk;
	logic          rst;
	logic          button_left;
	logic          button_right;
	logic          button_display;
	logic          move_tick;
	pixel_pos_t    pixel;
	rgb_t          rgb;
	logic          test_done;
	int            test_id;
	coord_t        model_ship_x;
	formation_t    model_form;
	int            check_count;
	int            error_count;
	int            tests_failed;
	int            tb_errors;

	invaders_display i_invaders_display (
		.clk(clk), .rst(rst), .button_left(button_left), .button_right(button_right),
		.button_display(button_display), .move_tick(move_tick), .pixel(pixel), .rgb(rgb)
	);

	invaders_checker i_invaders_checker (
		.clk(clk), .rst(rst), .button_left(button_left), .button_right(button_right),
		.button_display(button_display), .move_tick(move_tick), .pixel(pixel), .rgb(rgb),
		.test_done(test_done), .test_id(test_id), .stim_errors(tb_errors),
		.model_ship_x(model_ship_x), .model_form(model_form), .check_count(check_count),
		.error_count(error_count), .tests_failed(tests_failed)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////
	// Stimulus tasks driving on the falling edge

	task automatic probe(int x, int y);
		@(negedge clk);
		pixel = '{x: coord_t'(x), y: coord_t'(y)};
	endtask

	// Two corners inside and four neighbours just outside
	task automatic probe_box(int x0, int y0, int w, int h);
		probe(x0, y0);
		probe(x0 + w - 1, y0 + h - 1);
		probe(x0 - 1, y0);
		probe(x0 + w, y0);
		probe(x0, y0 - 1);
		probe(x0, y0 + h);
	endtask

	task automatic probe_row();
		int fx;
		int fy;
		fx = int'(model_form.x);
		fy = int'(model_form.y);
		probe_box(fx, fy, `ALIEN_W, `ALIEN_H);
		// Right edge of the last alien
		probe(fx + LAST_OFS + `ALIEN_W - 1, fy);
		probe(fx + LAST_OFS + `ALIEN_W, fy);
	endtask

	task automatic move(logic left, logic right);
		@(negedge clk);
		button_left  = left;
		button_right = right;
		move_tick    = 1'b1;
		@(negedge clk);
		move_tick    = 1'b0;
		button_left  = 1'b0;
		button_right = 1'b0;
	endtask

	// Held past the synchronizer and then the three-cycle mode latency
	task automatic press_display();
		@(negedge clk);
		button_display = 1'b1;
		repeat (3) @(negedge clk);
		button_display = 1'b0;
		repeat (4) @(negedge clk);
	endtask

	task automatic random_pixels(int n);
		repeat (n) probe($urandom_range(0, 1023), $urandom_range(0, 1023));
	endtask

	task automatic end_test(int id);
		@(negedge clk);
		test_id   = id;
		test_done = 1'b1;
		@(negedge clk);
		test_done = 1'b0;
	endtask

	//////////////////////////////
	// Watchdog

	initial begin
		#(TEST_CYCLES * 2 * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish",
			TEST_CYCLES * 2);
		$display("SIMULATION FAILED");
		$finish;
	end

	//////////////////////////////
	// Test sequence

	initial begin
		int   n;
		int   floor_turns;
		int   sel;
		march_dir_t last_dir;
		clk            = 1'b0;
		rst            = 1'b1;
		button_left    = 1'b0;
		button_right   = 1'b0;
		button_display = 1'b0;
		move_tick      = 1'b0;
		pixel          = '0;
		test_done      = 1'b0;
		test_id        = 0;
		tb_errors      = 0;
		void'($urandom(69099));
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		// Blank after reset
		random_pixels(N_RANDOM);
		end_test(1);

		// Start, game, blank
		press_display();
		probe_box(`TITLE_X0, `TITLE_Y0, `TITLE_X1 - `TITLE_X0, `TITLE_Y1 - `TITLE_Y0);
		random_pixels(40);
		press_display();
		probe_box(int'(model_ship_x), `SHIP_Y, `SHIP_W, `SHIP_H);
		probe_row();
		random_pixels(40);
		press_display();
		random_pixels(40);
		end_test(2);

		// Ship pushed past both screen edges
		press_display();
		press_display();
		// Both buttons together leave the ship in place
		move(1'b1, 1'b1);
		probe_box(int'(model_ship_x), `SHIP_Y, `SHIP_W, `SHIP_H);
		repeat (SHIP_LEFT) begin
			move(1'b1, 1'b0);
			probe_box(int'(model_ship_x), `SHIP_Y, `SHIP_W, `SHIP_H);
		end
		repeat (SHIP_RIGHT) begin
			move(1'b0, 1'b1);
			probe_box(int'(model_ship_x), `SHIP_Y, `SHIP_W, `SHIP_H);
		end
		end_test(3);

		// Formation down to the floor and two turns there
		n           = 0;
		floor_turns = 0;
		while (floor_turns < 2 && n < FORM_TICKS) begin
			last_dir = model_form.dir;
			move(1'b0, 1'b0);
			if (model_form.dir != last_dir && int'(model_form.y) == `ALIEN_FLOOR_Y)
				floor_turns++;
			probe_row();
			n++;
		end
		if (floor_turns < 2) begin
			$display("Alien row did not reach the floor within %0d ticks", FORM_TICKS);
			tb_errors++;
		end
		// Row returns home after leaving the game and coming back
		press_display();
		random_pixels(20);
		press_display();
		press_display();
		probe_row();
		end_test(4);

		// Random sweep with targeted rows and objects
		for (int i = 0; i < N_SWEEP; i++) begin
			if (i % 8 == 0)
				move($urandom_range(0, 1) == 1, $urandom_range(0, 1) == 1);
			sel = $urandom_range(0, 3);
			case (sel)
				0: probe($urandom_range(0, 1023), $urandom_range(0, 1023));
				1: probe($urandom_range(0, 639), $urandom_range(0, 2) == 0 ?
					`BARRIER_LINE_Y : ($urandom_range(0, 1) == 0 ?
					`LIVES_TOP_Y : `LIVES_BOTTOM_Y));
				2: probe(int'(model_ship_x) - 2 + $urandom_range(0, `SHIP_W + 3),
					`SHIP_Y - 2 + $urandom_range(0, `SHIP_H + 3));
				default: probe(int'(model_form.x) - 2 + $urandom_range(0, LAST_OFS +
					`ALIEN_W + 3), int'(model_form.y) - 2 + $urandom_range(0, `ALIEN_H + 3));
			endcase
		end
		end_test(5);

		@(posedge clk);
		$display("Tests failed: %0d of 5, checks: %0d, errors: %0d", tests_failed,
			check_count, error_count + tb_errors);
		if (error_count == 0 && tb_errors == 0 && check_count > 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tests/invaders_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "invaders_defines.svh"

module invaders_checker
	import video_pkg::*;
	import game_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  logic          button_left,
	input  logic          button_right,
	input  logic          button_display,
	input  logic          move_tick,
	input  pixel_pos_t    pixel,
	input  rgb_t          rgb,
	input  logic          test_done,
	input  int            test_id,
	input  int            stim_errors,
	output coord_t        model_ship_x,
	output formation_t    model_form,
	output int            check_count,
	output int            error_count,
	output int            tests_failed
);

	localparam int ROW_W = (`ALIEN_COUNT - 1) * `ALIEN_PITCH + `ALIEN_W;
	localparam formation_t FORM_HOME = '{x: coord_t'(`ALIEN_START_X),
		y: coord_t'(`ALIEN_START_Y), dir: MARCH_RIGHT};

	// Synchronizer model with the previous synced level in bit 2
	logic [2:0]    btn_hist;
	display_mode_t model_mode;
	rgb_t          exp_rgb;
	pixel_pos_t    exp_pixel;
	logic          exp_valid;
	int            mark_checks;
	int            mark_errors;

	function automatic logic in_box(int px, int py, int x0, int y0, int w, int h);
		return px >= x0 && px < x0 + w && py >= y0 && py < y0 + h;
	endfunction

	function automatic logic hits_alien(int px, int py, int fx, int fy);
		logic hit;
		hit = 1'b0;
		for (int k = 0; k < `ALIEN_COUNT; k++) begin
			if (in_box(px, py, fx + k * `ALIEN_PITCH, fy, `ALIEN_W, `ALIEN_H))
				hit = 1'b1;
		end
		return hit;
	endfunction

	//////////////////////////////
	// Expected color from the model

	function automatic rgb_t ref_color(display_mode_t m, int sx, int fx, int fy,
		int px, int py);
		rgb_t c;
		c = rgb_t'(`COLOR_BLACK);
		if (px < `H_VISIBLE && py < `V_VISIBLE) begin
			if (m == MODE_START) begin
				if (in_box(px, py, `TITLE_X0, `TITLE_Y0, `TITLE_X1 - `TITLE_X0,
					`TITLE_Y1 - `TITLE_Y0))
					c = rgb_t'(`COLOR_YELLOW);
			end else if (m == MODE_GAME) begin
				// Barrier over ship over alien over lives
				if (py == `BARRIER_LINE_Y)
					c = rgb_t'(`COLOR_BLUE);
				else if (in_box(px, py, sx, `SHIP_Y, `SHIP_W, `SHIP_H))
					c = rgb_t'(`COLOR_SPACESHIP);
				else if (hits_alien(px, py, fx, fy))
					c = rgb_t'(`COLOR_ALIEN);
				else if (py == `LIVES_TOP_Y || py == `LIVES_BOTTOM_Y)
					c = rgb_t'(`COLOR_GREEN);
			end
		end
		return c;
	endfunction

	function automatic int next_ship_x(int x, logic left, logic right);
		if (left && !right && x >= `SHIP_STEP)
			return x - `SHIP_STEP;
		if (right && !left && x + `SHIP_W + `SHIP_STEP <= `H_VISIBLE)
			return x + `SHIP_STEP;
		return x;
	endfunction

	function automatic formation_t next_form(formation_t f);
		formation_t n;
		logic       at_edge;
		n = f;
		if (f.dir == MARCH_RIGHT)
			at_edge = int'(f.x) + ROW_W + `ALIEN_STEP > `H_VISIBLE;
		else
			at_edge = int'(f.x) < `ALIEN_STEP;
		if (at_edge) begin
			// Reverse and drop only while above the floor
			n.dir = (f.dir == MARCH_RIGHT) ? MARCH_LEFT : MARCH_RIGHT;
			if (int'(f.y) < `ALIEN_FLOOR_Y)
				n.y = coord_t'(int'(f.y) + `ALIEN_DROP);
		end else if (f.dir == MARCH_RIGHT) begin
			n.x = coord_t'(int'(f.x) + `ALIEN_STEP);
		end else begin
			n.x = coord_t'(int'(f.x) - `ALIEN_STEP);
		end
		return n;
	endfunction

	//////////////////////////////
	// Model state stepped at each clk edge

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			btn_hist     <= 3'b000;
			model_mode   <= MODE_BLANK;
			model_ship_x <= coord_t'(`SHIP_START_X);
			model_form   <= FORM_HOME;
			exp_valid    <= 1'b0;
		end else begin
			// Color for this pixel from positions before the update
			exp_rgb   <= ref_color(model_mode, int'(model_ship_x), int'(model_form.x),
				int'(model_form.y), int'(pixel.x), int'(pixel.y));
			exp_pixel <= pixel;
			exp_valid <= 1'b1;
			btn_hist  <= {btn_hist[1:0], button_display};
			if (btn_hist[1] && !btn_hist[2]) begin
				case (model_mode)
					MODE_BLANK: model_mode <= MODE_START;
					MODE_START: model_mode <= MODE_GAME;
					default:    model_mode <= MODE_BLANK;
				endcase
			end
			if (model_mode != MODE_GAME) begin
				model_ship_x <= coord_t'(`SHIP_START_X);
				model_form   <= FORM_HOME;
			end else if (move_tick) begin
				model_ship_x <= coord_t'(next_ship_x(int'(model_ship_x), button_left,
					button_right));
				model_form   <= next_form(model_form);
			end
		end
	end

	// rgb is settled at the falling edge
	always @(negedge clk) begin
		if (rst) begin
			check_count = 0;
			error_count = 0;
		end else if (exp_valid) begin
			check_count++;
			if (rgb !== exp_rgb) begin
				error_count++;
				$display("Error at time %0t: rgb = %h, expected %h (pixel x=%0d y=%0d)",
					$time, rgb, exp_rgb, exp_pixel.x, exp_pixel.y);
			end
		end
	end

	//////////////////////////////
	// Per-test report

	always @(posedge clk) begin
		if (rst) begin
			tests_failed = 0;
			mark_checks  = 0;
			mark_errors  = 0;
		end else if (test_done) begin
			if (error_count + stim_errors != mark_errors)
				tests_failed++;
			$display("Test %0d: %0d checks, %0d errors", test_id,
				check_count - mark_checks, error_count + stim_errors - mark_errors);
			mark_checks = check_count;
			mark_errors = error_count + stim_errors;
		end
	end

endmodule

`default_nettype wire

/* verilog/invaders_display.sv */
`timescale 1ns/1ps
`default_nettype none

module invaders_display
	import video_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       button_left,
	input  logic       button_right,
	input  logic       button_display,
	input  logic       move_tick,
	input  pixel_pos_t pixel,
	output rgb_t       rgb
);

	display_mode_t mode;
	logic          play;
	logic          is_ship;
	logic          is_alien;

	// Display button steps the screen mode
	screen_mode_ctrl i_screen_mode_ctrl (
		.clk            (clk),
		.rst            (rst),
		.button_display (button_display),
		.mode           (mode),
		.play           (play)
	);

	// Player ship, moved by left and right buttons
	spaceship_ctrl i_spaceship_ctrl (
		.clk          (clk),
		.rst          (rst),
		.play         (play),
		.move_tick    (move_tick),
		.button_left  (button_left),
		.button_right (button_right),
		.pixel        (pixel),
		.is_ship      (is_ship)
	);

	// Marching alien row
	alien_formation i_alien_formation (
		.clk       (clk),
		.rst       (rst),
		.play      (play),
		.move_tick (move_tick),
		.pixel     (pixel),
		.is_alien  (is_alien)
	);

	// Final color, registered
	pixel_compositor i_pixel_compositor (
		.clk      (clk),
		.rst      (rst),
		.mode     (mode),
		.pixel    (pixel),
		.is_ship  (is_ship),
		.is_alien (is_alien),
		.rgb      (rgb)
	);

endmodule

`default_nettype wire

/* verilog/pixel_compositor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "invaders_defines.svh"

module pixel_compositor
	import video_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  display_mode_t mode,
	input  pixel_pos_t    pixel,
	input  logic          is_ship,
	input  logic          is_alien,
	output rgb_t          rgb
);

	rgb_t color_next;
	logic in_visible;
	logic in_title;
	logic on_barrier;
	logic on_lives;

	//////////////////////////////
	// Region decode

	assign in_visible = (pixel.x < coord_t'(`H_VISIBLE)) &&
		(pixel.y < coord_t'(`V_VISIBLE));

	// Title box, upper bounds excluded
	assign in_title = (pixel.x >= coord_t'(`TITLE_X0)) &&
		(pixel.x < coord_t'(`TITLE_X1)) &&
		(pixel.y >= coord_t'(`TITLE_Y0)) &&
		(pixel.y < coord_t'(`TITLE_Y1));

	// Single-row playfield lines
	assign on_barrier = (pixel.y == coord_t'(`BARRIER_LINE_Y));
	assign on_lives   = (pixel.y == coord_t'(`LIVES_TOP_Y)) ||
		(pixel.y == coord_t'(`LIVES_BOTTOM_Y));

	//////////////////////////////
	// Color select

	always_comb begin
		color_next = rgb_t'(`COLOR_BLACK);
		if (in_visible) begin
			case (mode)
				MODE_START: begin
					if (in_title) begin
						color_next = rgb_t'(`COLOR_YELLOW);
					end
				end
				MODE_GAME: begin
					// Barrier line wins over everything
					if (on_barrier) begin
						color_next = rgb_t'(`COLOR_BLUE);
					end else if (is_ship) begin
						color_next = rgb_t'(`COLOR_SPACESHIP);
					end else if (is_alien) begin
						color_next = rgb_t'(`COLOR_ALIEN);
					end else if (on_lives) begin
						color_next = rgb_t'(`COLOR_GREEN);
					end
				end
				// Blank screen
				default: color_next = rgb_t'(`COLOR_BLACK);
			endcase
		end
	end

	// One cycle behind the pixel sample
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rgb <= rgb_t'(`COLOR_BLACK);
		end else begin
			rgb <= color_next;
		end
	end

	a_blank_is_black: assert property (@(posedge clk) disable iff (rst)
		(mode == MODE_BLANK) |=> (rgb == rgb_t'(`COLOR_BLACK)));

endmodule

`default_nettype wire

/* verilog/alien_formation.sv */
`timescale 1ns/1ps
`default_nettype none

`include "invaders_defines.svh"

module alien_formation
	import video_pkg::*;
	import game_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       play,
	input  logic       move_tick,
	input  pixel_pos_t pixel,
	output logic       is_alien
);

	// Leftmost alien's left edge to last alien's right edge
	localparam int ROW_W = (`ALIEN_COUNT - 1) * `ALIEN_PITCH + `ALIEN_W;

	formation_t              form;
	formation_t              form_next;
	coord_ext_t              row_right;
	coord_ext_t              row_right_stepped;
	logic                    at_edge;
	logic                    can_drop;
	logic                    in_row;
	logic [`ALIEN_COUNT-1:0] alien_hit;

	//////////////////////////////
	// March rule

	// Row's right boundary now and after one more step right
	assign row_right         = coord_ext_t'(form.x) + coord_ext_t'(ROW_W);
	assign row_right_stepped = row_right + coord_ext_t'(`ALIEN_STEP);

	// Next step would leave the screen
	assign at_edge = (form.dir == MARCH_RIGHT) ?
		(row_right_stepped > coord_ext_t'(`H_VISIBLE)) :
		(form.x < coord_t'(`ALIEN_STEP));

	// Descent stops at the floor, reversal still happens
	assign can_drop = form.y < coord_t'(`ALIEN_FLOOR_Y);

	always_comb begin
		form_next = form;
		if (at_edge) begin
			// Turn around, step down instead of sideways
			form_next.dir = (form.dir == MARCH_RIGHT) ? MARCH_LEFT : MARCH_RIGHT;
			if (can_drop) begin
				form_next.y = form.y + coord_t'(`ALIEN_DROP);
			end
		end else if (form.dir == MARCH_RIGHT) begin
			form_next.x = form.x + coord_t'(`ALIEN_STEP);
		end else begin
			form_next.x = form.x - coord_t'(`ALIEN_STEP);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			form <= FORMATION_START;
		end else if (!play) begin
			// Held at start off the game screen
			form <= FORMATION_START;
		end else if (move_tick) begin
			form <= form_next;
		end
	end

	//////////////////////////////
	// Hit test

	// Shared row band for all six boxes
	assign in_row = (pixel.y >= form.y) &&
		(coord_ext_t'(pixel.y) < coord_ext_t'(form.y) + coord_ext_t'(`ALIEN_H));

	for (genvar k = 0; k < `ALIEN_COUNT; k++) begin : g_alien
		coord_ext_t alien_left;

		// Alien k sits k pitches right of the leftmost
		assign alien_left = coord_ext_t'(form.x) + coord_ext_t'(k * `ALIEN_PITCH);
		assign alien_hit[k] = in_row &&
			(coord_ext_t'(pixel.x) >= alien_left) &&
			(coord_ext_t'(pixel.x) < alien_left + coord_ext_t'(`ALIEN_W));
	end

	assign is_alien = |alien_hit;

	// Edge turns keep the row on screen and above the floor band
	a_row_on_screen: assert property (@(posedge clk) disable iff (rst)
		(row_right <= coord_ext_t'(`H_VISIBLE)) &&
		(form.y <= coord_t'(`ALIEN_FLOOR_Y)));

endmodule

`default_nettype wire

/* verilog/spaceship_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "invaders_defines.svh"

module spaceship_ctrl
	import video_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       play,
	input  logic       move_tick,
	input  logic       button_left,
	input  logic       button_right,
	input  pixel_pos_t pixel,
	output logic       is_ship
);

	coord_t     ship_x;
	coord_ext_t ship_right;
	coord_ext_t stepped_right;
	logic       go_left;
	logic       go_right;
	logic       in_rows;

	// Both buttons together cancel out
	assign go_left  = button_left & ~button_right;
	assign go_right = button_right & ~button_left;

	// First column past the ship, now and after a right step
	assign ship_right    = coord_ext_t'(ship_x) + coord_ext_t'(`SHIP_W);
	assign stepped_right = ship_right + coord_ext_t'(`SHIP_STEP);

	//////////////////////////////
	// Position register

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ship_x <= coord_t'(`SHIP_START_X);
		end else if (!play) begin
			// Parked at start outside the game screen
			ship_x <= coord_t'(`SHIP_START_X);
		end else if (move_tick) begin
			if (go_left && ship_x >= coord_t'(`SHIP_STEP)) begin
				ship_x <= ship_x - coord_t'(`SHIP_STEP);
			end else if (go_right && stepped_right <= coord_ext_t'(`H_VISIBLE)) begin
				ship_x <= ship_x + coord_t'(`SHIP_STEP);
			end
		end
	end

	//////////////////////////////
	// Hit test, half-open box

	assign in_rows = (pixel.y >= coord_t'(`SHIP_Y)) &&
		(pixel.y < coord_t'(`SHIP_Y + `SHIP_H));

	assign is_ship = in_rows && (pixel.x >= ship_x) &&
		(coord_ext_t'(pixel.x) < ship_right);

	// Clamping keeps the whole ship on screen across any button sequence
	a_ship_on_screen: assert property (@(posedge clk) disable iff (rst)
		ship_right <= coord_ext_t'(`H_VISIBLE));

endmodule

`default_nettype wire

/* verilog/screen_mode_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module screen_mode_ctrl
	import video_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  logic          button_display,
	output display_mode_t mode,
	output logic          play
);

	logic btn_meta;
	logic btn_sync;
	logic btn_prev;
	logic btn_rise;

	// Two-flop synchronizer and a third flop holding the last level for the edge
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			btn_meta <= 1'b0;
			btn_sync <= 1'b0;
			btn_prev <= 1'b0;
		end else begin
			btn_meta <= button_display;
			btn_sync <= btn_meta;
			btn_prev <= btn_sync;
		end
	end

	assign btn_rise = btn_sync & ~btn_prev;

	// Blank, start, game, then back to blank
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mode <= MODE_BLANK;
		end else if (btn_rise) begin
			case (mode)
				MODE_BLANK: mode <= MODE_START;
				MODE_START: mode <= MODE_GAME;
				default:    mode <= MODE_BLANK;
			endcase
		end
	end

	// Objects run only on the game screen
	assign play = (mode == MODE_GAME);

	a_mode_legal: assert property (@(posedge clk) disable iff (rst)
		mode inside {MODE_BLANK, MODE_START, MODE_GAME});

endmodule

`default_nettype wire

/* verilog/game_pkg.sv */
`default_nettype none

`include "invaders_defines.svh"

package game_pkg;

	import video_pkg::*;

	// Sideways direction of the alien row
	typedef enum logic {
		MARCH_RIGHT = 1'b0,
		MARCH_LEFT  = 1'b1
	} march_dir_t;

	// Row state, tracked for the leftmost alien
	// Other aliens follow at fixed pitch
	typedef struct packed {
		coord_t     x;
		coord_t     y;
		march_dir_t dir;
	} formation_t;

	// Position after reset and whenever the game screen is left
	localparam formation_t FORMATION_START = '{
		x:   coord_t'(`ALIEN_START_X),
		y:   coord_t'(`ALIEN_START_Y),
		dir: MARCH_RIGHT
	};

endpackage

`default_nettype wire

/* verilog/video_pkg.sv */
`default_nettype none

`include "invaders_defines.svh"

package video_pkg;

	// One screen coordinate
	typedef logic [`COORD_W-1:0] coord_t;

	// One bit wider, for edge sums that may run past the screen
	typedef logic [`COORD_W:0] coord_ext_t;

	// Scan position from the VGA timing, x in the upper half
	typedef struct packed {
		coord_t x;
		coord_t y;
	} pixel_pos_t;

	// 8-bit color, blue on top
	typedef struct packed {
		logic [1:0] blue;
		logic [2:0] green;
		logic [2:0] red;
	} rgb_t;

	// Screen shown, stepped by the display button
	typedef enum logic [1:0] {
		MODE_BLANK = 2'd0,
		MODE_START = 2'd1,
		MODE_GAME  = 2'd2
	} display_mode_t;

endpackage

`default_nettype wire

/* verilog/invaders_defines.svh */
`ifndef INVADERS_DEFINES_SVH
`define INVADERS_DEFINES_SVH

//////////////////////////////
// Screen geometry

// Visible area, anything past it is black
`define H_VISIBLE 640
`define V_VISIBLE 480
// Bits in one screen coordinate
`define COORD_W 10

//////////////////////////////
// Colors, packed as [ blue | green | red ]

`define COLOR_SPACESHIP 8'b01111000
`define COLOR_ALIEN     8'b10101010
`define COLOR_BLACK     8'b00000000
`define COLOR_GREEN     8'b00111000
`define COLOR_BLUE      8'b11000000
`define COLOR_YELLOW    8'b00111111

//////////////////////////////
// Playfield markings

// Blue line under the barrier zone
`define BARRIER_LINE_Y 400
// Green lines framing the extra-lives band
`define LIVES_TOP_Y    445
`define LIVES_BOTTOM_Y 479

// Start screen title box, lower bounds in, upper bounds out
`define TITLE_X0 200
`define TITLE_X1 440
`define TITLE_Y0 200
`define TITLE_Y1 280

//////////////////////////////
// Player ship

`define SHIP_START_X 300
`define SHIP_Y       420
`define SHIP_W       40
`define SHIP_H       16
`define SHIP_STEP    4

//////////////////////////////
// Alien row

`define ALIEN_COUNT   6
// Left edge to left edge of neighbours
`define ALIEN_PITCH   50
`define ALIEN_W       30
`define ALIEN_H       20
`define ALIEN_START_X 195
`define ALIEN_START_Y 180
// Sideways step per tick and drop at an edge
`define ALIEN_STEP    5
`define ALIEN_DROP    10
// No more drops once y reaches this
`define ALIEN_FLOOR_Y 360

`endif
